// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t; // RV32E has sixteen registers

	typedef enum logic [3:0] {
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_branch_eq,
		op_branch_ne,
		op_load_word,
		op_store_word,
		op_add_imm,
		op_add,
		op_sub,
		op_illegal
	} op_kind_e;

	typedef enum logic [2:0] {
		state_fetch,
		state_execute,
		state_memory,
		state_retire,
		state_halt
	} core_state_e;

	typedef struct packed {
		op_kind_e op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm; // Already sign-extended
		logic writes_rd;
	} decoded_t;

	typedef struct packed {
		logic write;
		word_t addr;
		word_t wdata;
		logic [3:0] wstrb;
	} dmem_req_t;

	typedef struct packed {
		word_t pc;
		reg_idx_t rd;
		logic writes_rd;
		word_t value;
	} retire_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter core_pkg::word_t reset_pc = '0
) (
	input  logic clock,
	input  logic rst,
	output logic imem_req,
	output core_pkg::word_t imem_addr,
	input  logic imem_valid,
	input  core_pkg::word_t imem_rdata,
	input  logic needs_mem,
	input  logic mem_done,
	input  logic illegal,
	input  core_pkg::word_t next_pc,
	output core_pkg::core_state_e state,
	output core_pkg::word_t pc,
	output core_pkg::word_t inst
);

	logic fetch_done;

	assign fetch_done = imem_req && imem_valid;
	assign imem_addr = pc;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= core_pkg::state_fetch;
			imem_req <= 1'b0;
			pc <= reset_pc;
		end else begin
			case (state)
				core_pkg::state_fetch: begin
					// The request comes up one cycle after reset and stays until answered
					if (fetch_done) begin
						state <= core_pkg::state_execute;
						imem_req <= 1'b0;
					end else begin
						imem_req <= 1'b1;
					end
				end
				core_pkg::state_execute: begin
					if (illegal)
						state <= core_pkg::state_halt;
					else if (needs_mem)
						state <= core_pkg::state_memory;
					else
						state <= core_pkg::state_retire;
				end
				core_pkg::state_memory: begin
					if (mem_done)
						state <= core_pkg::state_retire;
				end
				core_pkg::state_retire: begin
					pc <= next_pc;
					state <= core_pkg::state_fetch;
					imem_req <= 1'b1; // Next fetch starts right after retirement
				end
				default: state <= core_pkg::state_halt; // Halt is kept until reset
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_done)
			inst <= imem_rdata;
	end

	// The fetch address must not move while a request is outstanding
	assert property (@(posedge clock) disable iff (rst)
		imem_req && !imem_valid |=> $stable(imem_addr));

endmodule

`default_nettype wire

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  core_pkg::word_t inst,
	output core_pkg::decoded_t decoded,
	output logic needs_mem,
	output logic illegal
);

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	core_pkg::op_kind_e op;
	core_pkg::word_t imm;
	logic uses_rd, uses_rs1, uses_rs2;
	logic bad_index;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		op = core_pkg::op_illegal;
		imm = imm_i;
		uses_rd = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			opc_lui: begin op = core_pkg::op_lui; imm = imm_u; uses_rd = 1'b1; end
			opc_auipc: begin op = core_pkg::op_auipc; imm = imm_u; uses_rd = 1'b1; end
			opc_jal: begin op = core_pkg::op_jal; imm = imm_j; uses_rd = 1'b1; end
			opc_jalr: if (funct3 == 3'b000) begin
				op = core_pkg::op_jalr; uses_rd = 1'b1; uses_rs1 = 1'b1;
			end
			opc_branch: if (funct3 == 3'b000 || funct3 == 3'b001) begin
				op = funct3[0] ? core_pkg::op_branch_ne : core_pkg::op_branch_eq;
				imm = imm_b; uses_rs1 = 1'b1; uses_rs2 = 1'b1;
			end
			opc_load: if (funct3 == 3'b010) begin
				op = core_pkg::op_load_word; uses_rd = 1'b1; uses_rs1 = 1'b1;
			end
			opc_store: if (funct3 == 3'b010) begin
				op = core_pkg::op_store_word; imm = imm_s; uses_rs1 = 1'b1; uses_rs2 = 1'b1;
			end
			opc_op_imm: if (funct3 == 3'b000) begin
				op = core_pkg::op_add_imm; uses_rd = 1'b1; uses_rs1 = 1'b1;
			end
			opc_op: if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
				op = funct7[5] ? core_pkg::op_sub : core_pkg::op_add;
				uses_rd = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1;
			end
			default: ;
		endcase
	end

	// Bit 4 of any used register field points past the sixteen RV32E registers
	assign bad_index = (uses_rd && inst[11]) || (uses_rs1 && inst[19]) || (uses_rs2 && inst[24]);

	assign illegal = (op == core_pkg::op_illegal) || bad_index;
	assign needs_mem = (op == core_pkg::op_load_word) || (op == core_pkg::op_store_word);

	assign decoded.op = illegal ? core_pkg::op_illegal : op;
	assign decoded.rd = inst[10:7];
	assign decoded.rs1 = inst[18:15];
	assign decoded.rs2 = inst[23:20];
	assign decoded.imm = imm;
	assign decoded.writes_rd = uses_rd && !illegal && inst[11:7] != 5'd0; // x0 is never written

endmodule

`default_nettype wire

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  core_pkg::decoded_t decoded,
	input  core_pkg::word_t pc,
	input  core_pkg::word_t src1,
	input  core_pkg::word_t src2,
	output core_pkg::word_t result,
	output core_pkg::word_t next_pc,
	output core_pkg::word_t mem_addr
);

	core_pkg::word_t seq_pc;
	core_pkg::word_t pc_target;

	assign seq_pc = pc + 32'd4;
	assign pc_target = pc + decoded.imm; // Shared by AUIPC, JAL and branches
	assign mem_addr = src1 + decoded.imm;

	always_comb begin
		result = seq_pc; // Link value for JAL and JALR
		next_pc = seq_pc;
		case (decoded.op)
			core_pkg::op_lui: result = decoded.imm;
			core_pkg::op_auipc: result = pc_target;
			core_pkg::op_jal: next_pc = pc_target;
			core_pkg::op_jalr: next_pc = {mem_addr[31:1], 1'b0};
			core_pkg::op_branch_eq: begin
				if (src1 == src2)
					next_pc = pc_target;
			end
			core_pkg::op_branch_ne: begin
				if (src1 != src2)
					next_pc = pc_target;
			end
			core_pkg::op_add_imm: result = mem_addr;
			core_pkg::op_add: result = src1 + src2;
			core_pkg::op_sub: result = src1 - src2;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
	input  logic clock,
	input  logic rst,
	input  core_pkg::core_state_e state,
	input  core_pkg::decoded_t decoded,
	input  core_pkg::word_t mem_addr,
	input  core_pkg::word_t src2,
	output logic dmem_req,
	output core_pkg::dmem_req_t dmem,
	input  logic dmem_valid,
	input  core_pkg::word_t dmem_rdata,
	output logic mem_done,
	output core_pkg::word_t load_data
);

	logic is_store;

	assign is_store = decoded.op == core_pkg::op_store_word;

	// The FSM leaves the memory state on the answer, so the request drops right after it
	assign dmem_req = state == core_pkg::state_memory;
	assign mem_done = dmem_req && dmem_valid;

	assign dmem.write = is_store;
	assign dmem.addr = mem_addr;
	assign dmem.wdata = src2;
	assign dmem.wstrb = is_store ? 4'b1111 : 4'b0000; // Only whole words are stored

	always_ff @(posedge clock) begin
		if (mem_done && !is_store)
			load_data <= dmem_rdata;
	end

	// Only LW and SW exist, so every access is a full aligned word
	assert property (@(posedge clock) disable iff (rst)
		dmem_req |-> dmem.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic clock,
	input  logic rst,
	input  core_pkg::reg_idx_t rs1,
	input  core_pkg::reg_idx_t rs2,
	output core_pkg::word_t src1,
	output core_pkg::word_t src2,
	input  logic wen,
	input  core_pkg::reg_idx_t rd,
	input  core_pkg::word_t wdata
);

	core_pkg::word_t regs [16];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wen && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == '0) ? '0 : regs[rs1];
	assign src2 = (rs2 == '0) ? '0 : regs[rs2];

	// Decode already clears writes_rd for x0, so no enable should reach index 0
	assert property (@(posedge clock) disable iff (rst) !(wen && rd == '0));

endmodule

`default_nettype wire

// ==== hdl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter core_pkg::word_t reset_pc = '0
) (
	input  logic clock,
	input  logic rst,
	output logic imem_req,
	output core_pkg::word_t imem_addr,
	input  logic imem_valid,
	input  core_pkg::word_t imem_rdata,
	output logic dmem_req,
	output core_pkg::dmem_req_t dmem,
	input  logic dmem_valid,
	input  core_pkg::word_t dmem_rdata,
	output logic retire_valid,
	output core_pkg::retire_t retire,
	output logic halted
);

	core_pkg::core_state_e state;
	core_pkg::word_t pc, inst, next_pc, result, mem_addr;
	core_pkg::word_t src1, src2, load_data, wb_value;
	core_pkg::decoded_t decoded;
	logic needs_mem, illegal, mem_done;

	fetch_unit #(.reset_pc(reset_pc)) fetch (
		.clock(clock), .rst(rst),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_valid(imem_valid), .imem_rdata(imem_rdata),
		.needs_mem(needs_mem), .mem_done(mem_done), .illegal(illegal),
		.next_pc(next_pc), .state(state), .pc(pc), .inst(inst)
	);

	decode_unit decode (
		.inst(inst), .decoded(decoded), .needs_mem(needs_mem), .illegal(illegal)
	);

	execute_unit execute (
		.decoded(decoded), .pc(pc), .src1(src1), .src2(src2),
		.result(result), .next_pc(next_pc), .mem_addr(mem_addr)
	);

	load_store_unit lsu (
		.clock(clock), .rst(rst), .state(state), .decoded(decoded),
		.mem_addr(mem_addr), .src2(src2),
		.dmem_req(dmem_req), .dmem(dmem),
		.dmem_valid(dmem_valid), .dmem_rdata(dmem_rdata),
		.mem_done(mem_done), .load_data(load_data)
	);

	register_file regs (
		.clock(clock), .rst(rst),
		.rs1(decoded.rs1), .rs2(decoded.rs2), .src1(src1), .src2(src2),
		.wen(retire_valid && decoded.writes_rd), .rd(decoded.rd), .wdata(wb_value)
	);

	assign wb_value = (decoded.op == core_pkg::op_load_word) ? load_data : result;

	// Retire lasts one cycle, which gives the single pulse per instruction
	assign retire_valid = state == core_pkg::state_retire;
	assign halted = state == core_pkg::state_halt;

	assign retire.pc = pc;
	assign retire.rd = decoded.rd;
	assign retire.writes_rd = decoded.writes_rd;
	assign retire.value = wb_value;

endmodule

`default_nettype wire

// ==== tb/core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
	parameter core_pkg::word_t reset_pc = '0
) (
	input  logic clock,
	input  logic rst,
	input  logic imem_req,
	input  core_pkg::word_t imem_addr,
	input  logic dmem_req,
	input  core_pkg::dmem_req_t dmem,
	input  logic dmem_valid,
	input  logic retire_valid,
	input  core_pkg::retire_t retire,
	input  logic halted,
	output int errors,
	output int retires_seen,
	output int stores_seen
);

	core_pkg::retire_t expected_retire [$];
	core_pkg::dmem_req_t expected_store [$];
	logic first_fetch_seen;

	initial begin : read_expected
		int fd;
		logic [7:0] kind;
		logic [1023:0] rest;
		core_pkg::word_t pc, value;
		core_pkg::reg_idx_t rd;
		logic writes;
		fd = $fopen("tb/program_input.txt", "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "R") begin
					void'($fscanf(fd, "%h %h %h %h", pc, rd, writes, value));
					expected_retire.push_back('{pc: pc, rd: rd, writes_rd: writes, value: value});
				end else if (kind == "S") begin
					void'($fscanf(fd, "%h %h", pc, value));
					expected_store.push_back('{write: 1'b1, addr: pc, wdata: value,
						wstrb: 4'b1111});
				end else if (kind == "M") begin
					void'($fscanf(fd, "%h %h", pc, value));
				end else begin
					void'($fgets(rest, fd));
				end
			end
			$fclose(fd);
		end
	end

	// Outputs change after the rising edge, so the edge itself sees settled values
	always @(posedge clock) begin
		core_pkg::retire_t exp_r;
		core_pkg::dmem_req_t exp_s;
		if (rst) begin
			first_fetch_seen = 1'b0;
			if (retire_valid || imem_req || dmem_req || halted) begin
				$display("MISMATCH %0t: an output is high during reset", $time);
				errors++;
			end
		end else begin
			if (imem_req && !first_fetch_seen) begin
				first_fetch_seen = 1'b1;
				if (imem_addr !== reset_pc) begin
					$display("MISMATCH %0t: first fetch at %h, expected %h", $time, imem_addr, reset_pc);
					errors++;
				end
			end
			if (halted && (imem_req || dmem_req || retire_valid)) begin
				$display("Activity on a port at %0t while the core is halted", $time);
				errors++;
			end
			if (retire_valid) begin
				retires_seen++;
				if (expected_retire.size() == 0) begin
					$display("Extra retirement at pc %h after the last expected one", retire.pc);
					errors++;
				end else begin
					exp_r = expected_retire.pop_front();
					if (retire.pc !== exp_r.pc || retire.writes_rd !== exp_r.writes_rd ||
						(exp_r.writes_rd && (retire.rd !== exp_r.rd || retire.value !== exp_r.value))) begin
						$display("MISMATCH %0t: retire pc %h x%0d=%h w%0b, expected pc %h x%0d=%h w%0b",
							$time, retire.pc, retire.rd, retire.value, retire.writes_rd,
							exp_r.pc, exp_r.rd, exp_r.value, exp_r.writes_rd);
						errors++;
					end
				end
			end
			if (dmem_req && dmem_valid && dmem.write) begin
				stores_seen++;
				if (expected_store.size() == 0) begin
					$display("Extra store to %h after the last expected one", dmem.addr);
					errors++;
				end else begin
					exp_s = expected_store.pop_front();
					if (dmem !== exp_s) begin
						$display("MISMATCH %0t: store %h=%h strb %b, expected %h=%h strb %b", $time,
							dmem.addr, dmem.wdata, dmem.wstrb, exp_s.addr, exp_s.wdata, exp_s.wstrb);
						errors++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam core_pkg::word_t start_pc = 32'h0000_0000;

	logic clock = 1'b0;
	logic rst;
	logic imem_req, imem_valid, dmem_req, dmem_valid;
	logic retire_valid, halted;
	core_pkg::word_t imem_addr, imem_rdata, dmem_rdata;
	core_pkg::dmem_req_t dmem;
	core_pkg::retire_t retire;

	core_pkg::word_t mem [256]; // 1 KB image shared by both ports
	int expected_retires, expected_stores;
	int check_errors, retires_seen, stores_seen;
	logic loaded = 1'b0;

	core_top #(.reset_pc(start_pc)) dut (
		.clock(clock), .rst(rst),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.imem_valid(imem_valid), .imem_rdata(imem_rdata),
		.dmem_req(dmem_req), .dmem(dmem),
		.dmem_valid(dmem_valid), .dmem_rdata(dmem_rdata),
		.retire_valid(retire_valid), .retire(retire), .halted(halted)
	);

	core_checker #(.reset_pc(start_pc)) scoreboard (
		.clock(clock), .rst(rst),
		.imem_req(imem_req), .imem_addr(imem_addr),
		.dmem_req(dmem_req), .dmem(dmem), .dmem_valid(dmem_valid),
		.retire_valid(retire_valid), .retire(retire), .halted(halted),
		.errors(check_errors), .retires_seen(retires_seen), .stores_seen(stores_seen)
	);

	always #10 clock = ~clock;

	task automatic load_memory_image(output bit ok);
		int fd;
		logic [7:0] kind;
		logic [1023:0] rest;
		core_pkg::word_t addr, data, skip0, skip1;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hdead0000 | (i << 2); // Unwritten words carry their own address
		expected_retires = 0;
		expected_stores = 0;
		fd = $fopen("tb/program_input.txt", "r");
		ok = fd != 0;
		if (!ok) begin
			$display("Cannot open tb/program_input.txt");
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "M") begin
					void'($fscanf(fd, "%h %h", addr, data));
					mem[addr[9:2]] = data;
				end else if (kind == "R") begin
					void'($fscanf(fd, "%h %h %h %h", skip0, skip1, addr, data));
					expected_retires++;
				end else if (kind == "S") begin
					void'($fscanf(fd, "%h %h", addr, data));
					expected_stores++;
				end else begin
					void'($fgets(rest, fd)); // Comment line
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin : imem_model
		int delay;
		imem_valid = 1'b0;
		imem_rdata = '0;
		forever begin
			@(negedge clock);
			imem_valid = 1'b0;
			if (imem_req && !rst) begin
				delay = $urandom_range(0, 4);
				repeat (delay) @(negedge clock);
				imem_rdata = mem[imem_addr[9:2]];
				imem_valid = 1'b1;
			end
		end
	end

	initial begin : dmem_model
		int delay;
		dmem_valid = 1'b0;
		dmem_rdata = '0;
		forever begin
			@(negedge clock);
			dmem_valid = 1'b0;
			if (dmem_req && !rst) begin
				delay = $urandom_range(0, 4);
				repeat (delay) @(negedge clock);
				dmem_rdata = mem[dmem.addr[9:2]];
				if (dmem.write) begin
					for (int b = 0; b < 4; b++)
						if (dmem.wstrb[b])
							mem[dmem.addr[9:2]][8*b +: 8] = dmem.wdata[8*b +: 8];
				end
				dmem_valid = 1'b1; // Doubles as the write acknowledge
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (loaded);
		limit = (expected_retires + expected_stores) * 40 + 10;
		repeat (limit) @(posedge clock);
		$display("TIMEOUT: the core did not halt within %0d cycles", limit);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : run
		int end_errors;
		bit image_ok;
		end_errors = 0;
		void'($urandom(32'h05164cca));
		rst = 1'b1;
		load_memory_image(image_ok);
		if (!image_ok) begin
			$display("RESULT: FAIL");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (5) @(negedge clock);
			rst = 1'b0;
			wait (halted);
			repeat (10) @(negedge clock); // Let the checker see that the core stays quiet
			if (retires_seen != expected_retires) begin
				$display("Retirements seen %0d, expected %0d", retires_seen, expected_retires);
				end_errors++;
			end
			if (stores_seen != expected_stores) begin
				$display("Stores seen %0d, expected %0d", stores_seen, expected_stores);
				end_errors++;
			end
			if (!halted) begin
				$display("The core left the halt state without a reset");
				end_errors++;
			end
			$display("Errors: %0d in checks, %0d at end of run", check_errors, end_errors);
			if (check_errors == 0 && end_errors == 0)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/program_input.txt ====
# Columns: M addr word | R pc rd writes_rd value | S addr data (all hex)
# Program starts at 0 with data at 0x100 and ends on the illegal zero word at 0x64
M 00000000 123450b7
M 00000004 00001117
M 00000008 06400193
M 0000000c ffd00213
M 00000010 004182b3
M 00000014 40418333
M 00000018 00718013
M 0000001c 000003b3
M 00000020 00418463
M 00000024 00419463
M 00000028 00100413
M 0000002c 00529463
M 00000030 00528463
M 00000034 00200413
M 00000038 008004ef
M 0000003c 00300413
M 00000040 05100513
M 00000044 ffc505e7
M 00000048 00400413
M 0000004c 10000613
M 00000050 00162423
M 00000054 00862683
M 00000058 00062703
M 0000005c 00e687b3
M 00000060 00f62223
M 00000064 00000000
M 00000100 cafef00d
R 00000000 1 1 12345000
R 00000004 2 1 00001004
R 00000008 3 1 00000064
R 0000000c 4 1 fffffffd
R 00000010 5 1 00000061
R 00000014 6 1 00000067
R 00000018 0 0 00000000
R 0000001c 7 1 00000000
R 00000020 0 0 00000000
R 00000024 0 0 00000000
R 0000002c 0 0 00000000
R 00000030 0 0 00000000
R 00000038 9 1 0000003c
R 00000040 a 1 00000051
R 00000044 b 1 00000048
R 0000004c c 1 00000100
R 00000050 0 0 00000000
R 00000054 d 1 12345000
R 00000058 e 1 cafef00d
R 0000005c f 1 dd33400d
R 00000060 0 0 00000000
S 00000108 12345000
S 00000104 dd33400d

// ==== sim.f ====
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/load_store_unit.sv
hdl/register_file.sv
hdl/core_top.sv
tb/core_checker.sv
tb/core_tb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP   = core_tb
FLIST = sim.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
